// ==== flist.f ====
hdl/histPkg.sv
hdl/timestampBinner.sv
hdl/histogramRam.sv
hdl/peakTracker.sv
hdl/histogramPeakTop.sv
sim/histogramPeak_sva.sv
sim/histogramPeakTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP = histogramPeakTb
FLIST = flist.f
OBJDIR = obj_dir
PASSTEXT = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSTEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

// ==== sim/histogramPeakTb.sv ====
`timescale 1ns/1ps

module histogramPeakTb;

    localparam int timeWidth = histPkg::timeWidthDef;
    localparam int binWidth = histPkg::binWidthDef;
    localparam int countWidth = histPkg::countWidthDef;
    localparam int pixelNum = histPkg::pixelNumDef;
    localparam int stampsPerPixel = histPkg::stampsPerPixelDef;
    localparam int acqNum = histPkg::acqNumDef;
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1;

    localparam int clkPeriod = 40;
    localparam int passLen = pixelNum * stampsPerPixel * acqNum;   // stamps per pass
    localparam int gapCycles = pixelNum + 3;                       // idle cycles after a pass
    localparam int timeMax = (1 << timeWidth) - 1;
    localparam int binNum = 1 << binWidth;             // coarse bins and fine window width
    localparam int coarseW = 1 << (timeWidth - binWidth);
    localparam int splitDelta = 2;                     // offset of the split stamps
    localparam int rowNum = 5;

    // one row per test, centres chosen near the middle of a coarse bin
    string rowName [rowNum] = '{"midCluster", "edgeBins", "heavyNoise", "shiftedFrame",
                                "sameBinRuns"};
    int rowCentre [rowNum][pixelNum] = '{
        '{290, 414, 547, 735},
        '{30, 994, 35, 989},
        '{225, 482, 670, 866},
        '{802, 158, 355, 606},
        '{286, 420, 540, 738}
    };
    int rowJitter [rowNum] = '{4, 3, 3, 5, 0};
    int rowNoise [rowNum] = '{0, 0, 3, 1, 0};   // uniform stamps per pixel and acquisition
    int rowSplit [rowNum] = '{0, 0, 0, 0, 3};   // stamps moved up by splitDelta

    logic clk;
    logic combin_res;
    logic stampValid;
    logic [timeWidth-1:0] stamp;
    logic resultValid;
    logic [pixW-1:0] resultPixel;
    logic [timeWidth-1:0] peakTime;
    logic fineActive;

    int seed;
    int coarseStamps [passLen];
    int fineStamps [passLen];
    int expLow [pixelNum];      // predicted window per pixel
    int resPixelQ [$];
    int resTimeQ [$];
    int errorCount;
    int testsPassed;

    histogramPeakTop #(
        .timeWidth(timeWidth),
        .binWidth(binWidth),
        .countWidth(countWidth),
        .pixelNum(pixelNum),
        .stampsPerPixel(stampsPerPixel),
        .acqNum(acqNum)
    ) i_histogramPeakTop (
        .clk(clk),
        .combin_res(combin_res),
        .stampValid(stampValid),
        .stamp(stamp),
        .resultValid(resultValid),
        .resultPixel(resultPixel),
        .peakTime(peakTime),
        .fineActive(fineActive)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // collect the result stream
    always @(posedge clk) begin
        if (resultValid) begin
            resPixelQ.push_back(int'(resultPixel));
            resTimeQ.push_back(int'(peakTime));
        end
    end

    function automatic int pixelOf(input int k);
        return (k / stampsPerPixel) % pixelNum;
    endfunction

    function automatic int drawStamp(input int row, input int pix, input int slot);
        int value;
        if (slot < rowNoise[row]) begin
            value = int'($unsigned($random(seed)) % (timeMax + 1));   // noise over the full range
        end else begin
            value = rowCentre[row][pix];
            if (slot < rowNoise[row] + rowSplit[row]) begin
                value = value + splitDelta;
            end
            value = value + int'($unsigned($random(seed)) % (2 * rowJitter[row] + 1))
                    - rowJitter[row];
        end
        if (value < 0) begin
            value = 0;
        end else if (value > timeMax) begin
            value = timeMax;
        end
        return value;
    endfunction

    // coarse histogram, first bin to reach the top wins, then the clamped window
    function automatic int coarseLow(input int pix);
        int cnt [binNum];
        int best;
        int peak;
        int bin;
        int low;
        best = 0;
        peak = 0;
        foreach (cnt[b]) begin
            cnt[b] = 0;
        end
        for (int k = 0; k < passLen; k++) begin
            if (pixelOf(k) == pix) begin
                bin = coarseStamps[k] / coarseW;
                cnt[bin]++;
                if (cnt[bin] > best) begin
                    best = cnt[bin];
                    peak = bin;
                end
            end
        end
        low = peak * coarseW + coarseW / 2 - binNum / 2;
        if (low < 0) begin
            low = 0;
        end else if (low > timeMax + 1 - binNum) begin
            low = timeMax + 1 - binNum;
        end
        return low;
    endfunction

    function automatic int finePeakTime(input int pix, input int low);
        int cnt [binNum];
        int best;
        int peak;
        int fb;
        best = 0;
        peak = 0;
        foreach (cnt[b]) begin
            cnt[b] = 0;
        end
        for (int k = 0; k < passLen; k++) begin
            if (pixelOf(k) == pix && fineStamps[k] >= low && fineStamps[k] < low + binNum) begin
                fb = fineStamps[k] - low;
                cnt[fb]++;
                if (cnt[fb] > best) begin
                    best = cnt[fb];
                    peak = fb;
                end
            end
        end
        return low + peak;
    endfunction

    task automatic reportMismatch(input string test, input string what, input int expected,
                                  input int actual);
        $display("error %s %s: expected %0d, actual %0d", test, what, expected, actual);
        errorCount++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            stampValid = 1'b0;
        end
    endtask

    // one full pass followed by the required gap
    task automatic sendPass(input int row, input bit fine);
        for (int k = 0; k < passLen; k++) begin
            @(negedge clk);
            if (fineActive !== fine) begin
                reportMismatch(rowName[row], $sformatf("fineActive before stamp %0d", k),
                               int'(fine), int'(fineActive));
            end
            stampValid = 1'b1;
            stamp = timeWidth'(fine ? fineStamps[k] : coarseStamps[k]);
        end
        @(negedge clk);
        stampValid = 1'b0;
        if (fineActive !== !fine) begin     // flips right after the last stamp
            reportMismatch(rowName[row], "fineActive after the last stamp", int'(!fine),
                           int'(fineActive));
        end
        idle(gapCycles - 1);
    endtask

    task automatic runRow(input int row);
        int rowStart;
        int expTime;
        int waited;
        rowStart = errorCount;
        resPixelQ.delete();
        resTimeQ.delete();
        for (int k = 0; k < passLen; k++) begin
            coarseStamps[k] = drawStamp(row, pixelOf(k), k % stampsPerPixel);
        end
        for (int p = 0; p < pixelNum; p++) begin
            expLow[p] = coarseLow(p);
        end
        sendPass(row, 1'b0);
        for (int k = 0; k < passLen; k++) begin
            fineStamps[k] = drawStamp(row, pixelOf(k), k % stampsPerPixel);
        end
        sendPass(row, 1'b1);
        waited = 0;
        while (resTimeQ.size() < pixelNum && waited < 2 * gapCycles) begin
            @(negedge clk);
            waited++;
        end
        if (resTimeQ.size() < pixelNum) begin
            $display("test %s: the result stream stopped after %0d of %0d results",
                     rowName[row], resTimeQ.size(), pixelNum);
            errorCount++;
        end
        idle(gapCycles);    // stray strobes would show up here
        if (resTimeQ.size() != pixelNum) begin
            reportMismatch(rowName[row], "result count", pixelNum, resTimeQ.size());
        end
        for (int p = 0; p < pixelNum && p < resTimeQ.size(); p++) begin
            expTime = finePeakTime(p, expLow[p]);
            if (resPixelQ[p] != p) begin
                reportMismatch(rowName[row], $sformatf("pixel of result %0d", p), p,
                               resPixelQ[p]);
            end
            if (resTimeQ[p] != expTime) begin
                reportMismatch(rowName[row], $sformatf("peakTime of pixel %0d", p), expTime,
                               resTimeQ[p]);
            end
        end
        if (errorCount == rowStart) begin
            $display("test %s passed", rowName[row]);
            testsPassed++;
        end else begin
            $display("test %s failed with %0d mismatches", rowName[row], errorCount - rowStart);
        end
    endtask

    initial begin
        seed = 52252;
        errorCount = 0;
        testsPassed = 0;
        combin_res = 1'b0;
        stampValid = 1'b0;
        stamp = '0;
        repeat (4) @(negedge clk);
        combin_res = 1'b1;
        if (resultValid !== 1'b0) begin
            reportMismatch("reset", "resultValid", 0, int'(resultValid));
        end
        if (fineActive !== 1'b0) begin
            reportMismatch("reset", "fineActive", 0, int'(fineActive));
        end
        if (errorCount == 0) begin
            $display("test reset passed");
            testsPassed++;
        end else begin
            $display("test reset failed with %0d mismatches", errorCount);
        end
        for (int r = 0; r < rowNum; r++) begin
            runRow(r);
        end
        $display("summary: %0d of %0d tests passed, %0d mismatches", testsPassed, rowNum + 1,
                 errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog, twice the expected length of all rows
    initial begin
        longint limitNs;
        limitNs = longint'(4 + rowNum * 2 * (passLen + 2 * gapCycles)) * clkPeriod * 2;
        #(limitNs);
        $display("timeout: the run did not finish within %0d ns", limitNs);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== sim/histogramPeak_sva.sv ====
`timescale 1ns/1ps

module histogramPeakSva #(
    parameter int timeWidth = histPkg::timeWidthDef,
    parameter int pixelNum = histPkg::pixelNumDef,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input logic                  clk,
    input logic                  combin_res,
    input logic                  stampValid,
    input logic                  fineActive,
    input logic                  binWrite,
    input logic [pixW-1:0]       pixelIdx,
    input logic [timeWidth-1:0]  windowLow,
    input logic                  doneStrobe,
    input histPkg::histPass_e    doneKind,
    input logic                  resultValid,
    input logic [pixW-1:0]       resultPixel,
    input logic [timeWidth-1:0]  peakTime
);

    logic [timeWidth-1:0] seenLow [pixelNum];   // windows as the binner used them

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixelNum; p++) begin
                seenLow[p] <= '0;
            end
        end else if (stampValid && fineActive) begin
            seenLow[pixelIdx] <= windowLow;
        end
    end

    noResultOnCoarseEnd: assert property (@(posedge clk) disable iff (!combin_res)
        (doneStrobe && doneKind == histPkg::passCoarse) |-> !resultValid)
        else $error("result strobe during the coarse to fine change");

    peakInsideWindow: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> (peakTime >= seenLow[resultPixel]))
        else $error("peak time below the window of pixel %0d", resultPixel);

    noWriteOnDone: assert property (@(posedge clk) disable iff (!combin_res)
        doneStrobe |-> !binWrite)
        else $error("bin write while the pass end is still pending");

endmodule

bind histogramPeakTop histogramPeakSva #(
    .timeWidth(timeWidth),
    .pixelNum(pixelNum)
) i_histogramPeakSva (
    .clk(clk),
    .combin_res(combin_res),
    .stampValid(stampValid),
    .fineActive(fineActive),
    .binWrite(binWrite),
    .pixelIdx(pixelIdx),
    .windowLow(windowLow),
    .doneStrobe(doneStrobe),
    .doneKind(doneKind),
    .resultValid(resultValid),
    .resultPixel(resultPixel),
    .peakTime(peakTime)
);

// ==== hdl/histogramPeakTop.sv ====
`timescale 1ns/1ps

module histogramPeakTop #(
    parameter int timeWidth = histPkg::timeWidthDef,
    parameter int binWidth = histPkg::binWidthDef,
    parameter int countWidth = histPkg::countWidthDef,
    parameter int pixelNum = histPkg::pixelNumDef,
    parameter int stampsPerPixel = histPkg::stampsPerPixelDef,
    parameter int acqNum = histPkg::acqNumDef,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  stampValid,
    input  logic [timeWidth-1:0]  stamp,
    output logic                  resultValid,
    output logic [pixW-1:0]       resultPixel,
    output logic [timeWidth-1:0]  peakTime,
    output logic                  fineActive
);

    // binner to RAM
    logic binWrite;
    logic [binWidth-1:0] binAddr;
    logic [pixW-1:0] pixelIdx;
    logic passEnd;
    histPkg::histPass_e passKind;

    // RAM to tracker
    logic countValid;
    logic [countWidth-1:0] binCount;
    logic [binWidth-1:0] countBin;
    logic [pixW-1:0] countPixel;
    logic doneStrobe;
    histPkg::histPass_e doneKind;

    logic [timeWidth-1:0] windowLow;    // window of pixelIdx, looked up in the tracker

    assign fineActive = (passKind == histPkg::passFine);

    timestampBinner #(
        .timeWidth(timeWidth),
        .binWidth(binWidth),
        .pixelNum(pixelNum),
        .stampsPerPixel(stampsPerPixel),
        .acqNum(acqNum)
    ) i_timestampBinner (
        .clk(clk),
        .combin_res(combin_res),
        .stampValid(stampValid),
        .stamp(stamp),
        .windowLow(windowLow),
        .binWrite(binWrite),
        .binAddr(binAddr),
        .pixelIdx(pixelIdx),
        .passEnd(passEnd),
        .passKind(passKind)
    );

    histogramRam #(
        .binWidth(binWidth),
        .countWidth(countWidth),
        .pixelNum(pixelNum)
    ) i_histogramRam (
        .clk(clk),
        .combin_res(combin_res),
        .binWrite(binWrite),
        .binAddr(binAddr),
        .pixelIdx(pixelIdx),
        .passEnd(passEnd),
        .passKind(passKind),
        .countValid(countValid),
        .binCount(binCount),
        .countBin(countBin),
        .countPixel(countPixel),
        .doneStrobe(doneStrobe),
        .doneKind(doneKind)
    );

    peakTracker #(
        .timeWidth(timeWidth),
        .binWidth(binWidth),
        .countWidth(countWidth),
        .pixelNum(pixelNum)
    ) i_peakTracker (
        .clk(clk),
        .combin_res(combin_res),
        .countValid(countValid),
        .binCount(binCount),
        .countBin(countBin),
        .countPixel(countPixel),
        .doneStrobe(doneStrobe),
        .doneKind(doneKind),
        .windowPixel(pixelIdx),
        .windowLow(windowLow),
        .resultValid(resultValid),
        .resultPixel(resultPixel),
        .peakTime(peakTime)
    );

endmodule

// ==== hdl/peakTracker.sv ====
`timescale 1ns/1ps

module peakTracker #(
    parameter int timeWidth = histPkg::timeWidthDef,
    parameter int binWidth = histPkg::binWidthDef,
    parameter int countWidth = histPkg::countWidthDef,
    parameter int pixelNum = histPkg::pixelNumDef,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   countValid,
    input  logic [countWidth-1:0]  binCount,
    input  logic [binWidth-1:0]    countBin,
    input  logic [pixW-1:0]        countPixel,
    input  logic                   doneStrobe,
    input  histPkg::histPass_e     doneKind,
    input  logic [pixW-1:0]        windowPixel,
    output logic [timeWidth-1:0]   windowLow,
    output logic                   resultValid,
    output logic [pixW-1:0]        resultPixel,
    output logic [timeWidth-1:0]   peakTime
);

    localparam int subWidth = timeWidth - binWidth;    // log2 of the coarse bin width
    localparam int lowMax = (1 << timeWidth) - (1 << binWidth);

    logic [countWidth-1:0] runMax [pixelNum];
    logic [binWidth-1:0] peakBin [pixelNum];
    logic [timeWidth-1:0] winTable [pixelNum];
    logic [binWidth-1:0] effPeak [pixelNum];    // peak bins including the count in flight

    logic newPeak;
    logic streamOn;
    logic [pixW-1:0] streamIdx;

    // centre of the coarse bin, widened down by half the fine span and clamped
    function automatic logic [timeWidth-1:0] windowOf(input logic [binWidth-1:0] peak);
        int centre;
        int low;
        centre = (int'(peak) << subWidth) + ((1 << subWidth) >> 1);
        low = centre - (1 << (binWidth - 1));
        if (low < 0) begin
            low = 0;
        end else if (low > lowMax) begin
            low = lowMax;
        end
        return timeWidth'(low);
    endfunction

    assign windowLow = winTable[windowPixel];

    // strictly greater, so the first bin to reach the top stays the peak
    assign newPeak = countValid && (binCount > runMax[countPixel]);

    always_comb begin
        for (int p = 0; p < pixelNum; p++) begin
            effPeak[p] = peakBin[p];
        end
        if (newPeak) begin
            effPeak[countPixel] = countBin;     // last stamp of a pass arrives with the done
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixelNum; p++) begin
                runMax[p] <= '0;
                peakBin[p] <= '0;
                winTable[p] <= '0;
            end
            streamOn <= 1'b0;
            streamIdx <= '0;
            resultValid <= 1'b0;
            resultPixel <= '0;
            peakTime <= '0;
        end else begin
            if (doneStrobe) begin
                for (int p = 0; p < pixelNum; p++) begin
                    runMax[p] <= '0;
                    if (doneKind == histPkg::passCoarse) begin
                        winTable[p] <= windowOf(effPeak[p]);
                        peakBin[p] <= '0;           // fine pass starts from bin 0
                    end else begin
                        peakBin[p] <= effPeak[p];   // held for the result stream
                    end
                end
            end else if (newPeak) begin
                runMax[countPixel] <= binCount;
                peakBin[countPixel] <= countBin;
            end

            // result stream, pixel 0 first
            if (doneStrobe && doneKind == histPkg::passFine) begin
                resultValid <= 1'b1;
                resultPixel <= '0;
                peakTime <= winTable[0] + timeWidth'(effPeak[0]);
                streamIdx <= pixW'(pixelNum > 1);
                streamOn <= (pixelNum > 1);
            end else if (streamOn) begin
                resultValid <= 1'b1;
                resultPixel <= streamIdx;
                peakTime <= winTable[streamIdx] + timeWidth'(peakBin[streamIdx]);
                streamIdx <= streamIdx + 1'b1;
                streamOn <= (streamIdx != pixW'(pixelNum - 1));
            end else begin
                resultValid <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/histogramRam.sv ====
`timescale 1ns/1ps

module histogramRam #(
    parameter int binWidth = histPkg::binWidthDef,
    parameter int countWidth = histPkg::countWidthDef,
    parameter int pixelNum = histPkg::pixelNumDef,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1,
    localparam int binNum = 2 ** binWidth,
    localparam int entryNum = pixelNum * binNum,
    localparam int entryW = (entryNum > 1) ? $clog2(entryNum) : 1
) (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   binWrite,
    input  logic [binWidth-1:0]    binAddr,
    input  logic [pixW-1:0]        pixelIdx,
    input  logic                   passEnd,
    input  histPkg::histPass_e     passKind,
    output logic                   countValid,
    output logic [countWidth-1:0]  binCount,
    output logic [binWidth-1:0]    countBin,
    output logic [pixW-1:0]        countPixel,
    output logic                   doneStrobe,
    output histPkg::histPass_e     doneKind
);

    logic [countWidth-1:0] binMem [entryNum];   // pixel-major bin counters
    logic [entryNum-1:0] entryValid;            // invalid entry reads as zero

    logic [entryW-1:0] entryAddr;
    logic [countWidth-1:0] readCount;
    logic [countWidth-1:0] newCount;

    assign entryAddr = entryW'(int'(pixelIdx) * binNum + int'(binAddr));

    // a write always lands before the next read, so back to back hits are exact
    assign readCount = entryValid[entryAddr] ? binMem[entryAddr] : '0;
    assign newCount = readCount + 1'b1;

    always_ff @(posedge clk) begin
        if (binWrite) begin
            binMem[entryAddr] <= newCount;
        end
    end

    // count, bin and pixel travel together to the tracker
    always_ff @(posedge clk) begin
        if (binWrite) begin
            binCount <= newCount;
            countBin <= binAddr;
            countPixel <= pixelIdx;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
            countValid <= 1'b0;
            doneStrobe <= 1'b0;
            doneKind <= histPkg::passCoarse;
        end else begin
            countValid <= binWrite;
            doneStrobe <= passEnd;
            if (passEnd) begin
                doneKind <= passKind;       // the pass that just ended
            end

            if (passEnd) begin
                entryValid <= '0;           // whole histogram cleared in one cycle
            end else if (binWrite) begin
                entryValid[entryAddr] <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/timestampBinner.sv ====
`timescale 1ns/1ps

module timestampBinner #(
    parameter int timeWidth = histPkg::timeWidthDef,
    parameter int binWidth = histPkg::binWidthDef,
    parameter int pixelNum = histPkg::pixelNumDef,
    parameter int stampsPerPixel = histPkg::stampsPerPixelDef,
    parameter int acqNum = histPkg::acqNumDef,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1,
    localparam int stampW = (stampsPerPixel > 1) ? $clog2(stampsPerPixel) : 1,
    localparam int acqW = (acqNum > 1) ? $clog2(acqNum) : 1
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  stampValid,
    input  logic [timeWidth-1:0]  stamp,
    input  logic [timeWidth-1:0]  windowLow,   // window of the current pixel
    output logic                  binWrite,
    output logic [binWidth-1:0]   binAddr,
    output logic [pixW-1:0]       pixelIdx,
    output logic                  passEnd,
    output histPkg::histPass_e    passKind
);

    logic [stampW-1:0] stampCnt;    // stamp within the pixel
    logic [pixW-1:0] pixelCnt;      // pixel within the acquisition
    logic [acqW-1:0] acqCnt;        // acquisition within the pass

    logic lastStamp;
    logic lastPixel;
    logic lastAcq;

    logic [timeWidth:0] windowHigh;     // one past the window, may reach 2^timeWidth
    logic [timeWidth-1:0] fineOffset;
    logic inWindow;

    assign lastStamp = (stampCnt == stampW'(stampsPerPixel - 1));
    assign lastPixel = (pixelCnt == pixW'(pixelNum - 1));
    assign lastAcq = (acqCnt == acqW'(acqNum - 1));

    assign pixelIdx = pixelCnt;

    // fine window test against the tracker's table
    assign windowHigh = {1'b0, windowLow} + (timeWidth + 1)'(2 ** binWidth);
    assign fineOffset = stamp - windowLow;
    assign inWindow = (stamp >= windowLow) && ({1'b0, stamp} < windowHigh);

    always_comb begin
        if (passKind == histPkg::passCoarse) begin
            binAddr = stamp[timeWidth-1 -: binWidth];   // top bits pick the coarse bin
            binWrite = stampValid;
        end else begin
            binAddr = fineOffset[binWidth-1:0];
            binWrite = stampValid && inWindow;          // outside stamps are dropped
        end
    end

    // the last stamp ends the pass even when it was dropped
    assign passEnd = stampValid && lastStamp && lastPixel && lastAcq;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            stampCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            passKind <= histPkg::passCoarse;
        end else if (stampValid) begin
            if (lastStamp) begin
                stampCnt <= '0;
                if (lastPixel) begin
                    pixelCnt <= '0;
                    if (lastAcq) begin
                        acqCnt <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                stampCnt <= stampCnt + 1'b1;
            end

            if (passEnd) begin
                passKind <= (passKind == histPkg::passCoarse) ?
                            histPkg::passFine : histPkg::passCoarse;   // alternate passes
            end
        end
    end

endmodule

// ==== hdl/histPkg.sv ====
package histPkg;

    // default geometry of the histogrammer
    parameter int timeWidthDef = 10;       // timestamp bits
    parameter int binWidthDef = 4;         // 16 bins per histogram
    parameter int countWidthDef = 8;       // holds stampsPerPixel * acqNum

    // acquisition structure
    parameter int pixelNumDef = 4;
    parameter int stampsPerPixelDef = 8;   // stamps per pixel per acquisition
    parameter int acqNumDef = 4;           // acquisitions per pass

    // which of the two passes is running
    typedef enum logic {
        passCoarse = 1'b0,
        passFine   = 1'b1
    } histPass_e;

endpackage
